// File: Makefile
VERILATOR ?= verilator
TOP       := tb_frame_buffer
FILELIST  := tb.f
OBJDIR    := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert
FAIL_MSG  := SOME TESTS FAILED
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# an aborted run counts as a failure
run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/frame_buffer_asserts.sv
`timescale 1ns/1ps

// bus timing and pixel stream rules seen from the top level
module frame_buffer_asserts (
  input logic              clk,
  input logic              rst_n,
  input fb_pkg::bus_req_t  sys_req,
  input fb_pkg::bus_resp_t sys_resp,
  input logic              pixel_valid,
  input logic              frame_done,
  input logic              busy
);

  localparam int lat = fb_pkg::resp_latency;
  localparam int run = fb_pkg::pixels_per_word - 1; // pixel 0 to pixel 7 of one word

  logic sys_in_region;
  assign sys_in_region = (sys_req.padr[31:20] == fb_pkg::region_tag); // decodes to us

  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    sys_req.cyc && sys_in_region |-> ##lat sys_resp.ack)
    else $error("sys_resp.ack missing after an in-region request");

  no_ack_foreign: assert property (@(posedge clk) disable iff (!rst_n)
    sys_req.cyc && !sys_in_region |-> ##lat !sys_resp.ack)
    else $error("ack returned for a request outside the region");

  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done |=> !frame_done)
    else $error("frame_done longer than one cycle");

  // done sits on the last pixel of a word whose first pixel was valid
  done_on_pixel: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done |-> pixel_valid && $past(pixel_valid, run))
    else $error("frame_done not on the last pixel of a word");

  // a run only starts from a fetch and stops after the frame
  stream_needs_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(pixel_valid) |-> $past(busy))
    else $error("pixel_valid rose with no frame being fetched");

  idle_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done |=> !pixel_valid)
    else $error("pixel_valid still high after the frame ended");

endmodule

bind frame_buffer_subsystem frame_buffer_asserts frame_buffer_asserts_inst (
  .clk(clk), .rst_n(rst_n), .sys_req(sys_req), .sys_resp(sys_resp),
  .pixel_valid(pixel_valid), .frame_done(frame_done), .busy(busy)
);

// File: bench/tb_frame_buffer.sv
`timescale 1ns/1ps

module tb_frame_buffer;

  localparam int mem_words = 1024;
  localparam int aw = $clog2(mem_words);
  localparam int cw = aw + 1;                 // word_count width
  localparam int period = 8;
  localparam int lat = 3;                     // request edge to ack edge
  localparam logic [11:0] home_tag = 12'h000; // upper padr bits that select the memory

  // run lengths that size the watchdog
  localparam int n_rd = 64;
  localparam int n_part = 32;
  localparam int n_oor = 16;
  localparam int n_b2b = 200;
  localparam int n_frames = 3;
  localparam int max_words = 8;
  localparam int req_total = mem_words + n_rd + 8 * n_part + 8 * n_oor + n_b2b + 32;
  localparam int frame_total = n_frames * (max_words * 8 + 24);
  localparam int wd_limit_ns = (req_total + frame_total + 10) * period + 4000;

  // one expected system response
  typedef struct packed {
    logic [63:0]  due;   // negedge time at which ack must be seen
    logic [12:0]  tid;
    logic [3:0]   pri;
    logic         is_rd; // dat only checked on reads
    logic [255:0] dat;
  } exp_resp_t;

  logic                  clk;
  logic                  rst_n;
  fb_pkg::bus_req_t      sys_req;
  fb_pkg::bus_resp_t     sys_resp;
  logic                  start;
  logic [aw-1:0]         base_word;
  logic [cw-1:0]         word_count;
  logic                  busy;
  logic [31:0]           pixel;
  logic                  pixel_valid;
  logic                  frame_done;

  logic [255:0] model_mem [mem_words]; // mirror of the frame buffer
  exp_resp_t    exp_q[$];
  logic [31:0]  pix_q[$];              // pixels of the frame in flight
  logic [12:0]  tid_ctr = '0;
  logic         streaming = 1'b0;      // inside an unbroken pixel run
  int           errors = 0;
  int           checks = 0;
  int           frames_seen = 0;
  int           frames_due = 0;

  frame_buffer_subsystem #(
    .mem_words(mem_words)
  ) frame_buffer_subsystem_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .sys_req     (sys_req),
    .sys_resp    (sys_resp),
    .start       (start),
    .base_word   (base_word),
    .word_count  (word_count),
    .busy        (busy),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .frame_done  (frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // expected word after a byte-select write
  function automatic logic [255:0] merge_bytes(input logic [255:0] old_word,
                                               input logic [255:0] new_word,
                                               input logic [31:0] sel);
    logic [255:0] res;
    res = old_word;
    for (int b = 0; b < 32; b++) begin
      if (sel[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic logic [255:0] rand_word();
    logic [255:0] w;
    for (int i = 0; i < 8; i++) w[i*32 +: 32] = $urandom;
    return w;
  endfunction

  // noise in the ignored address bits
  function automatic logic [31:0] make_padr(input logic [11:0] tag, input logic [aw-1:0] w);
    logic [31:0] p;
    p = $urandom;
    p[31:20] = tag;
    p[aw+4:5] = w;
    return p;
  endfunction

  task automatic check(input string what, input logic [255:0] got, input logic [255:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // drive one request now and queue what it should return
  task automatic send(input logic we, input logic [31:0] sel, input logic [31:0] padr,
                      input logic [255:0] data);
    exp_resp_t     e;
    logic [aw-1:0] w;
    w = padr[aw+4:5];
    tid_ctr = tid_ctr + 13'd1;
    sys_req.cyc = 1'b1;
    sys_req.we = we;
    sys_req.sel = sel;
    sys_req.padr = padr;
    sys_req.data = data;
    sys_req.tid = tid_ctr;
    sys_req.pri = 4'($urandom);
    if (padr[31:20] == home_tag) begin // only an in-region request gets a response
      e.due = $time + 64'(lat * period);
      e.tid = tid_ctr;
      e.pri = sys_req.pri;
      e.is_rd = !we;
      e.dat = model_mem[w];            // reads see the word before this write
      exp_q.push_back(e);
      if (we) model_mem[w] = merge_bytes(model_mem[w], data, sel);
    end
  endtask

  // idle the bus and wait for every outstanding ack
  task automatic settle();
    int n;
    n = 0;
    @(negedge clk);
    sys_req = '0;
    while (exp_q.size() != 0 && n < lat + 4) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("ERROR: %0d system responses never arrived", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic begin_frame(input logic [aw-1:0] base, input logic [cw-1:0] cnt);
    logic [255:0]  wd;
    logic [aw-1:0] w;
    for (int i = 0; i < int'(cnt); i++) begin
      w = base + aw'(i);                  // wraps like the fetcher
      wd = model_mem[w];
      for (int p = 0; p < 8; p++) pix_q.push_back(wd[p*32 +: 32]); // pixel 0 lowest
    end
    frames_due++;
    @(negedge clk);
    start = 1'b1;
    base_word = base;
    word_count = cnt;
    @(negedge clk);
    start = 1'b0;
    check("busy after start", 256'(busy), 256'(1));
  endtask

  task automatic end_frame(input logic [cw-1:0] cnt);
    int n;
    n = 0;
    while (frames_seen < frames_due && n < int'(cnt) * 8 + 16) begin
      @(negedge clk);
      n++;
    end
    if (frames_seen < frames_due) begin
      errors++;
      $display("ERROR: frame_done not seen for a %0d word frame", cnt);
      frames_seen = frames_due;
    end
    check("busy after frame", 256'(busy), '0);
  endtask

  // system responses and the pixel stream sampled away from the rising edge
  always @(negedge clk) begin : compare
    exp_resp_t   e;
    logic [31:0] want;
    if (rst_n) begin
      if (exp_q.size() != 0 && exp_q[0].due == $time) begin
        e = exp_q.pop_front();
        if (!sys_resp.ack) begin
          errors++;
          $display("ERROR: no ack at %0d ns for tid %0d", $time, e.tid);
        end else begin
          check("sys_resp.tid", 256'(sys_resp.tid), 256'(e.tid));
          check("sys_resp.pri", 256'(sys_resp.pri), 256'(e.pri));
          if (e.is_rd) check("sys_resp.dat", sys_resp.dat, e.dat);
        end
      end else if (sys_resp.ack) begin
        errors++;
        $display("ERROR: ack at %0d ns that no request asked for", $time);
      end
      if (pixel_valid && pix_q.size() == 0) begin
        errors++;
        $display("ERROR: pixel_valid at %0d ns with no pixel due", $time);
      end else if (pixel_valid) begin
        want = pix_q.pop_front();
        check("pixel", 256'(pixel), 256'(want));
        check("frame_done", 256'(frame_done), 256'(pix_q.size() == 0)); // only on the last
        streaming = (pix_q.size() != 0);
        if (pix_q.size() == 0) frames_seen++;
      end else begin
        if (streaming) begin
          errors++;
          $display("ERROR: gap in the pixel stream at %0d ns", $time);
          streaming = 1'b0;
        end
        if (frame_done) begin
          errors++;
          $display("ERROR: frame_done without a pixel at %0d ns", $time);
        end
      end
    end
  end

  initial begin : watchdog
    #(wd_limit_ns);
    $display("ERROR: run did not finish within %0d ns", wd_limit_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [aw-1:0] base;
    logic [aw-1:0] w;
    logic [cw-1:0] cnt;
    int unsigned   first_draw;
    first_draw = $urandom(32'hbf723b45);  // one seed for the whole run
    rst_n = 1'b0;
    start = 1'b0;
    base_word = '0;
    word_count = '0;
    sys_req = '0;
    repeat (10) @(negedge clk);
    check("ack in reset", 256'(sys_resp.ack), '0);
    check("busy in reset", 256'(busy), '0);
    check("pixel_valid in reset", 256'(pixel_valid), '0);
    check("frame_done in reset", 256'(frame_done), '0);
    rst_n = 1'b1;

    for (int i = 0; i < mem_words; i++) begin // fill every word with full selects
      @(negedge clk);
      send(1'b1, '1, make_padr(home_tag, aw'(i)), rand_word());
    end
    for (int i = 0; i < n_rd; i++) begin
      @(negedge clk);
      send(1'b0, '1, make_padr(home_tag, aw'($urandom)), '0);
    end
    settle();

    for (int i = 0; i < n_part; i++) begin // partial write then read back
      w = aw'($urandom);
      @(negedge clk);
      send(1'b1, $urandom, make_padr(home_tag, w), rand_word());
      @(negedge clk);
      send(1'b0, '1, make_padr(home_tag, w), '0);
      settle();
    end

    for (int i = 0; i < n_oor; i++) begin // foreign region write must not land
      w = aw'($urandom);
      @(negedge clk);
      send(1'b1, '1, make_padr(12'($urandom % 4095 + 1), w), rand_word());
      @(negedge clk);
      send(1'b0, '1, make_padr(home_tag, w), '0);
      settle();
    end

    for (int i = 0; i < n_b2b; i++) begin // three in flight all the time
      @(negedge clk);
      send(1'($urandom), $urandom, make_padr(home_tag, aw'($urandom)), rand_word());
    end
    settle();

    repeat (2) begin
      base = aw'($urandom);
      cnt = cw'(1 + $urandom % max_words);
      begin_frame(base, cnt);
      end_frame(cnt);
    end

    // scanout with system traffic outside the frame plus a start while busy
    base = aw'($urandom);
    cnt = cw'(2 + $urandom % (max_words - 1));
    begin_frame(base, cnt);
    for (int i = 0; i < int'(cnt) * 8; i++) begin
      @(negedge clk);
      start = (i == 1);
      base_word = base + aw'(4);
      word_count = cnt + 1'b1;
      w = base + aw'(cnt) + aw'($urandom % (mem_words - int'(cnt)));
      send(1'($urandom), $urandom, make_padr(home_tag, w), rand_word());
    end
    settle();
    end_frame(cnt);

    repeat (4) @(negedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: src/delay_line.sv
`timescale 1ns/1ps

// register chain matching the memory read pipeline
// carries tid or pri from request to response
module delay_line #(
  parameter int width = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [width-1:0] d,
  output logic [width-1:0] q
);

  logic [width-1:0] taps [fb_pkg::resp_latency]; // one tap per pipeline stage

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < fb_pkg::resp_latency; i++) begin
        taps[i] <= '0;
      end
    end else begin
      taps[0] <= d;
      for (int i = 1; i < fb_pkg::resp_latency; i++) begin
        taps[i] <= taps[i-1]; // shift toward the response
      end
    end
  end

  assign q = taps[fb_pkg::resp_latency-1];

endmodule

// File: src/fb_pkg.sv
package fb_pkg;

  // word geometry shared by both memory ports and the pixel path
  localparam int word_bits = 256;
  localparam int pixel_bits = 32;
  localparam int pixels_per_word = word_bits / pixel_bits; // 8 pixels per fetched word
  localparam int sel_bits = word_bits / 8;                 // one select per byte lane

  // side-band widths, same as the processor bus
  localparam int tid_bits = 13;
  localparam int pri_bits = 4;

  // request strobe to ack, address stage plus two output registers
  localparam int resp_latency = 3;

  // padr[31:20] must match for the memory to respond
  localparam logic [11:0] region_tag = 12'h000;

  // request side, one cycle per transfer, no handshake back
  typedef struct packed {
    logic                  cyc;   // request strobe
    logic                  we;    // write
    logic [sel_bits-1:0]   sel;   // byte selects
    logic [31:0]           padr;  // byte address, bits 4:0 unused
    logic [word_bits-1:0]  data;  // write data
    logic [tid_bits-1:0]   tid;   // transaction id, echoed
    logic [pri_bits-1:0]   pri;   // priority, echoed
  } bus_req_t;

  // response side, ack lines up with dat
  typedef struct packed {
    logic                  ack;
    logic [tid_bits-1:0]   tid;
    logic [pri_bits-1:0]   pri;
    logic [word_bits-1:0]  dat;
  } bus_resp_t;

  // a word is bytes to the processor and pixels to the display
  // pix[0] sits in the lowest 32 bits
  typedef union packed {
    logic [word_bits-1:0]                        raw;
    logic [pixels_per_word-1:0][pixel_bits-1:0]  pix;
  } fb_word_u;

endpackage

// File: src/frame_buffer_memory.sv
`timescale 1ns/1ps

// true dual-port word memory
// system port reads and byte-writes, frame buffer port only reads
module frame_buffer_memory #(
  parameter int mem_words = 1024
) (
  input  logic              clk,
  input  logic              rst_n,
  input  fb_pkg::bus_req_t  sys_req,
  output fb_pkg::bus_resp_t sys_resp,
  input  fb_pkg::bus_req_t  fb_req,
  output fb_pkg::bus_resp_t fb_resp
);

  localparam int aw = $clog2(mem_words);          // word address bits
  localparam int nbytes = fb_pkg::word_bits / 8;

  logic [nbytes-1:0][7:0] mem [mem_words];        // inferred array, powers up unknown

  logic sys_hit, fb_hit;                          // request lands in this region
  logic sys_en_q, fb_en_q, sys_wr_q;              // address stage control
  logic sys_rd_v, fb_rd_v;                        // read stage valid
  logic sys_ack_q, fb_ack_q;                      // output stage valid
  logic [aw-1:0] sys_addr_q, fb_addr_q;
  logic [nbytes-1:0] sys_sel_q;
  logic [nbytes-1:0][7:0] sys_data_q;
  logic [fb_pkg::word_bits-1:0] sys_rd_q, fb_rd_q;   // array output registers
  logic [fb_pkg::word_bits-1:0] sys_dat_q, fb_dat_q; // final output registers
  logic [fb_pkg::tid_bits-1:0] sys_tid, fb_tid;
  logic [fb_pkg::pri_bits-1:0] sys_pri, fb_pri;

  // upper 12 address bits select the memory
  assign sys_hit = sys_req.cyc && (sys_req.padr[31:20] == fb_pkg::region_tag);
  assign fb_hit  = fb_req.cyc && (fb_req.padr[31:20] == fb_pkg::region_tag); // we ignored here

  // strobes ride the same three stages as the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sys_en_q  <= 1'b0;
      sys_wr_q  <= 1'b0;
      fb_en_q   <= 1'b0;
      sys_rd_v  <= 1'b0;
      fb_rd_v   <= 1'b0;
      sys_ack_q <= 1'b0;
      fb_ack_q  <= 1'b0;
    end else begin
      sys_en_q  <= sys_hit;
      sys_wr_q  <= sys_hit && sys_req.we;
      fb_en_q   <= fb_hit;
      sys_rd_v  <= sys_en_q;
      fb_rd_v   <= fb_en_q;
      sys_ack_q <= sys_rd_v;
      fb_ack_q  <= fb_rd_v;
    end
  end

  // address stage
  always_ff @(posedge clk) begin
    sys_addr_q <= sys_req.padr[aw+4:5];  // bits 4:0 are the byte within the word
    sys_sel_q  <= sys_req.sel;
    sys_data_q <= sys_req.data;
    fb_addr_q  <= fb_req.padr[aw+4:5];
  end

  // array stage, reads see the word before a same-cycle write
  always_ff @(posedge clk) begin
    if (sys_en_q) sys_rd_q <= mem[sys_addr_q];
    if (fb_en_q) fb_rd_q <= mem[fb_addr_q];
    if (sys_wr_q) begin
      for (int b = 0; b < nbytes; b++) begin
        if (sys_sel_q[b]) mem[sys_addr_q][b] <= sys_data_q[b]; // byte lane write
      end
    end
  end

  // output register stage
  always_ff @(posedge clk) begin
    sys_dat_q <= sys_rd_q;
    fb_dat_q  <= fb_rd_q;
  end

  // tid and pri echoed back alongside ack
  delay_line #(.width(fb_pkg::tid_bits)) sys_tid_dly (
    .clk(clk), .rst_n(rst_n), .d(sys_req.tid), .q(sys_tid)
  );
  delay_line #(.width(fb_pkg::pri_bits)) sys_pri_dly (
    .clk(clk), .rst_n(rst_n), .d(sys_req.pri), .q(sys_pri)
  );
  delay_line #(.width(fb_pkg::tid_bits)) fb_tid_dly (
    .clk(clk), .rst_n(rst_n), .d(fb_req.tid), .q(fb_tid)
  );
  delay_line #(.width(fb_pkg::pri_bits)) fb_pri_dly (
    .clk(clk), .rst_n(rst_n), .d(fb_req.pri), .q(fb_pri)
  );

  always_comb begin
    sys_resp.ack = sys_ack_q;
    sys_resp.tid = sys_tid;
    sys_resp.pri = sys_pri;
    sys_resp.dat = sys_dat_q;   // old word on a write ack
    fb_resp.ack  = fb_ack_q;
    fb_resp.tid  = fb_tid;
    fb_resp.pri  = fb_pri;
    fb_resp.dat  = fb_dat_q;
  end

endmodule

// File: src/frame_buffer_subsystem.sv
`timescale 1ns/1ps

// frame buffer with processor port and display scanout
module frame_buffer_subsystem #(
  parameter int mem_words = 1024,
  localparam int aw = $clog2(mem_words)
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  fb_pkg::bus_req_t              sys_req,
  output fb_pkg::bus_resp_t             sys_resp,
  input  logic                          start,
  input  logic [aw-1:0]                 base_word,
  input  logic [aw:0]                   word_count,
  output logic                          busy,
  output logic [fb_pkg::pixel_bits-1:0] pixel,
  output logic                          pixel_valid,
  output logic                          frame_done
);

  fb_pkg::bus_req_t  fb_req;   // fetcher to memory
  fb_pkg::bus_resp_t fb_resp;  // memory to serializer and fetcher

  frame_buffer_memory #(
    .mem_words(mem_words)
  ) frame_buffer_memory_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .sys_req  (sys_req),
    .sys_resp (sys_resp),
    .fb_req   (fb_req),
    .fb_resp  (fb_resp)
  );

  scanout_fetcher #(
    .mem_words(mem_words)
  ) scanout_fetcher_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .base_word  (base_word),
    .word_count (word_count),
    .fb_req     (fb_req),
    .fb_ack     (fb_resp.ack),  // counts returned words
    .busy       (busy)
  );

  pixel_serializer pixel_serializer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .fb_resp     (fb_resp),
    .busy        (busy),        // tells it when the last word is in
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .frame_done  (frame_done)
  );

endmodule

// File: src/pixel_serializer.sv
`timescale 1ns/1ps

// turns each acked word into eight pixels, lowest first
module pixel_serializer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  fb_pkg::bus_resp_t            fb_resp,
  input  logic                         busy,       // fetcher still owes words
  output logic [fb_pkg::pixel_bits-1:0] pixel,
  output logic                         pixel_valid,
  output logic                         frame_done
);

  localparam int iw = $clog2(fb_pkg::pixels_per_word);
  localparam logic [iw-1:0] last_idx = iw'(fb_pkg::pixels_per_word - 1);

  fb_pkg::fb_word_u word_q;   // loaded raw, read out as pixels
  logic [iw-1:0]    idx_q;    // pixel being presented
  logic             active_q; // streaming a word

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx_q    <= '0;
      active_q <= 1'b0;
    end else begin
      if (fb_resp.ack) begin
        idx_q    <= '0;       // pixel 0 goes out next cycle
        active_q <= 1'b1;
      end else if (active_q) begin
        idx_q <= idx_q + 1'b1;
        if (idx_q == last_idx) active_q <= 1'b0; // word drained, no new one arrived
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fb_resp.ack) word_q.raw <= fb_resp.dat;
  end

  assign pixel       = word_q.pix[idx_q];
  assign pixel_valid = active_q;

  // busy low at the last pixel means no further word is due
  assign frame_done = active_q && (idx_q == last_idx) && !busy;

endmodule

// File: src/scanout_fetcher.sv
`timescale 1ns/1ps

// paced sequential reader for one frame
// one read every pixels_per_word cycles so the pixel stream never starves
module scanout_fetcher #(
  parameter int mem_words = 1024,
  localparam int aw = $clog2(mem_words)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,        // one-cycle pulse
  input  logic [aw-1:0]    base_word,
  input  logic [aw:0]      word_count,
  output fb_pkg::bus_req_t fb_req,
  input  logic             fb_ack,
  output logic             busy
);

  localparam int pw = $clog2(fb_pkg::pixels_per_word);
  localparam logic [pw-1:0] pace_top = pw'(fb_pkg::pixels_per_word - 1);
  localparam logic [fb_pkg::pri_bits-1:0] scan_pri = 4'hc; // display traffic runs high

  logic            busy_q;
  logic            cyc_q;
  logic [pw-1:0]   pace_q;        // cycles to the next read
  logic [aw-1:0]   word_q;        // word index of the read on the bus
  logic [aw:0]     issue_left;    // reads still to issue
  logic [aw:0]     ack_left;      // acks still to come back
  logic [fb_pkg::tid_bits-1:0] tid_q;
  logic            launch, next_rd;

  assign launch  = !busy_q && start && (word_count != '0); // start while busy is dropped
  assign next_rd = busy_q && (issue_left != '0) && (pace_q == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      cyc_q      <= 1'b0;
      pace_q     <= '0;
      word_q     <= '0;
      issue_left <= '0;
      ack_left   <= '0;
      tid_q      <= '0;
    end else begin
      cyc_q <= launch || next_rd;
      if (launch || next_rd) tid_q <= tid_q + 1'b1; // rolling id per read
      if (launch) begin
        busy_q     <= 1'b1;
        word_q     <= base_word;
        issue_left <= word_count - 1'b1;  // first read goes out now
        ack_left   <= word_count;
        pace_q     <= pace_top;
      end else if (busy_q) begin
        if (next_rd) begin
          word_q     <= word_q + 1'b1;
          issue_left <= issue_left - 1'b1;
          pace_q     <= pace_top;
        end else if (issue_left != '0) begin
          pace_q <= pace_q - 1'b1;
        end
        if (fb_ack) begin
          ack_left <= ack_left - 1'b1;
          if (ack_left == 1) busy_q <= 1'b0; // frame fully fetched
        end
      end
    end
  end

  // read-only requests into the region
  always_comb begin
    fb_req      = '0;
    fb_req.cyc  = cyc_q;
    fb_req.we   = 1'b0;
    fb_req.sel  = '1;
    fb_req.padr = {fb_pkg::region_tag, {(15-aw){1'b0}}, word_q, 5'b0};
    fb_req.tid  = tid_q;
    fb_req.pri  = scan_pri;
  end

  assign busy = busy_q;

endmodule

// File: tb.f
src/fb_pkg.sv
src/delay_line.sv
src/frame_buffer_memory.sv
src/scanout_fetcher.sv
src/pixel_serializer.sv
src/frame_buffer_subsystem.sv
bench/frame_buffer_asserts.sv
bench/tb_frame_buffer.sv
